// File: source/core_pkg.sv
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_t;

    // writeback source
    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } result_src_t;

    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_WB   = 2'b01,
        FWD_MEM  = 2'b10
    } fwd_sel_t;

    localparam opcode_t OP_R      = 7'b0110011;
    localparam opcode_t OP_I      = 7'b0010011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;

    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire

// File: source/stage_if.sv
`timescale 1ns/1ps
`default_nettype none

// decode to execute register outputs
interface decode_exec_io;
    logic                     reg_write;
    core_pkg::result_src_t    result_src;
    logic                     mem_write;
    logic                     branch;
    logic                     jump;
    logic                     alu_src;
    core_pkg::alu_op_t        alu_op;
    core_pkg::word_t          pc;
    core_pkg::word_t          pc_plus4;
    core_pkg::word_t          rd1;
    core_pkg::word_t          rd2;
    core_pkg::word_t          imm_ext;
    core_pkg::reg_idx_t       rs1;
    core_pkg::reg_idx_t       rs2;
    core_pkg::reg_idx_t       rd;

    modport src (output reg_write, result_src, mem_write, branch, jump, alu_src, alu_op,
                 output pc, pc_plus4, rd1, rd2, imm_ext, rs1, rs2, rd);
    modport dst (input reg_write, result_src, mem_write, branch, jump, alu_src, alu_op,
                 input pc, pc_plus4, rd1, rd2, imm_ext, rs1, rs2, rd);
endinterface

// execute to memory register outputs
interface exec_mem_io;
    logic                     reg_write;
    core_pkg::result_src_t    result_src;
    logic                     mem_write;
    core_pkg::word_t          alu_result;
    core_pkg::word_t          write_data;
    core_pkg::reg_idx_t       rd;
    core_pkg::word_t          pc_plus4;

    modport src (output reg_write, result_src, mem_write, alu_result, write_data, rd,
                 output pc_plus4);
    modport dst (input reg_write, result_src, mem_write, alu_result, write_data, rd,
                 input pc_plus4);
    // hazard unit only needs the destination side
    modport hz (input rd, reg_write, result_src);
endinterface

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  core_pkg::word_t   a,
    input  core_pkg::word_t   b,
    input  core_pkg::alu_op_t alu_op,
    output core_pkg::word_t   result,
    output logic              zero
);

    logic less;

    // signed compare for slt
    assign less = ($signed(a) < $signed(b));

    always_comb begin
        case (alu_op)
            core_pkg::ALU_ADD: result = a + b;
            core_pkg::ALU_SUB: result = a - b;
            core_pkg::ALU_AND: result = a & b;
            core_pkg::ALU_OR:  result = a | b;
            core_pkg::ALU_XOR: result = a ^ b;
            core_pkg::ALU_SLT: result = {31'b0, less};
            default:           result = a + b;
        endcase
    end

    // beq looks at this after a subtract
    assign zero = (result == '0);

endmodule

`default_nettype wire

// File: source/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  core_pkg::reg_idx_t ra1,
    input  core_pkg::reg_idx_t ra2,
    output core_pkg::word_t    rd1,
    output core_pkg::word_t    rd2,
    input  core_pkg::reg_idx_t wa,
    input  core_pkg::word_t    wd,
    input  logic               we
);

    core_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // write-first, so decode sees the value sitting in writeback
    assign rd1 = (ra1 == '0) ? '0 : ((we && wa == ra1) ? wd : regs[ra1]);
    assign rd2 = (ra2 == '0) ? '0 : ((we && wa == ra2) ? wd : regs[ra2]);

endmodule

`default_nettype wire

// File: source/decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode (
    input  logic               clk,
    input  logic               rst_n,
    input  core_pkg::word_t    instr_d,
    input  core_pkg::word_t    pc_d,
    input  core_pkg::word_t    pc_plus4_d,
    input  logic               flush_e,
    input  core_pkg::reg_idx_t rd_w,
    input  logic               reg_write_w,
    input  core_pkg::word_t    result_w,
    decode_exec_io.src         de
);

    core_pkg::opcode_t     opcode;
    core_pkg::funct3_t     funct3;
    logic [6:0]            funct7;
    core_pkg::reg_idx_t    rs1_d;
    core_pkg::reg_idx_t    rs2_d;
    core_pkg::reg_idx_t    rd_d;
    core_pkg::word_t       rd1_d;
    core_pkg::word_t       rd2_d;
    core_pkg::word_t       imm_ext_d;
    logic                  reg_write_d;
    core_pkg::result_src_t result_src_d;
    logic                  mem_write_d;
    logic                  branch_d;
    logic                  jump_d;
    logic                  alu_src_d;
    core_pkg::alu_op_t     alu_op_d;

    assign opcode = instr_d[6:0];
    assign funct3 = instr_d[14:12];
    assign funct7 = instr_d[31:25];
    assign rs1_d  = instr_d[19:15];
    assign rs2_d  = instr_d[24:20];
    assign rd_d   = instr_d[11:7];

    regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .ra1   (rs1_d),
        .ra2   (rs2_d),
        .rd1   (rd1_d),
        .rd2   (rd2_d),
        .wa    (rd_w),
        .wd    (result_w),
        .we    (reg_write_w)
    );

    function automatic core_pkg::alu_op_t f3_op(input core_pkg::funct3_t f3);
        case (f3)
            3'b111:  return core_pkg::ALU_AND;
            3'b110:  return core_pkg::ALU_OR;
            3'b100:  return core_pkg::ALU_XOR;
            3'b010:  return core_pkg::ALU_SLT;
            default: return core_pkg::ALU_ADD;
        endcase
    endfunction

    // unknown opcodes fall out as bubbles
    always_comb begin
        reg_write_d  = 1'b0;
        result_src_d = core_pkg::RES_ALU;
        mem_write_d  = 1'b0;
        branch_d     = 1'b0;
        jump_d       = 1'b0;
        alu_src_d    = 1'b0;
        alu_op_d     = core_pkg::ALU_ADD;
        imm_ext_d    = {{20{instr_d[31]}}, instr_d[31:20]};
        case (opcode)
            core_pkg::OP_R: begin
                reg_write_d = 1'b1;
                alu_op_d    = (funct3 == 3'b000 && funct7[5]) ? core_pkg::ALU_SUB : f3_op(funct3);
            end
            core_pkg::OP_I: begin
                reg_write_d = 1'b1;
                alu_src_d   = 1'b1;
                alu_op_d    = f3_op(funct3);
            end
            core_pkg::OP_LOAD: begin
                reg_write_d  = 1'b1;
                alu_src_d    = 1'b1;
                result_src_d = core_pkg::RES_MEM;
            end
            core_pkg::OP_STORE: begin
                mem_write_d = 1'b1;
                alu_src_d   = 1'b1;
                imm_ext_d   = {{20{instr_d[31]}}, instr_d[31:25], instr_d[11:7]};
            end
            core_pkg::OP_BRANCH: begin
                branch_d  = 1'b1;
                alu_op_d  = core_pkg::ALU_SUB;
                imm_ext_d = {{19{instr_d[31]}}, instr_d[31], instr_d[7],
                             instr_d[30:25], instr_d[11:8], 1'b0};
            end
            core_pkg::OP_JAL: begin
                reg_write_d  = 1'b1;
                jump_d       = 1'b1;
                result_src_d = core_pkg::RES_PC4;
                imm_ext_d    = {{11{instr_d[31]}}, instr_d[31], instr_d[19:12],
                                instr_d[20], instr_d[30:21], 1'b0};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush_e) begin
            de.reg_write  <= 1'b0;
            de.result_src <= core_pkg::RES_ALU;
            de.mem_write  <= 1'b0;
            de.branch     <= 1'b0;
            de.jump       <= 1'b0;
            de.alu_src    <= 1'b0;
            de.alu_op     <= core_pkg::ALU_ADD;
        end else begin
            de.reg_write  <= reg_write_d;
            de.result_src <= result_src_d;
            de.mem_write  <= mem_write_d;
            de.branch     <= branch_d;
            de.jump       <= jump_d;
            de.alu_src    <= alu_src_d;
            de.alu_op     <= alu_op_d;
        end
    end

    always_ff @(posedge clk) begin
        de.pc       <= pc_d;
        de.pc_plus4 <= pc_plus4_d;
        de.rd1      <= rd1_d;
        de.rd2      <= rd2_d;
        de.imm_ext  <= imm_ext_d;
        de.rs1      <= rs1_d;
        de.rs2      <= rs2_d;
        de.rd       <= rd_d;
    end

endmodule

`default_nettype wire

// File: source/exec.sv
`timescale 1ns/1ps
`default_nettype none

module exec (
    input  logic               clk,
    input  logic               rst_n,
    decode_exec_io.dst         de,
    exec_mem_io.src            em,
    input  core_pkg::word_t    alu_result_m,
    input  core_pkg::word_t    result_w,
    input  core_pkg::fwd_sel_t forward_a_e,
    input  core_pkg::fwd_sel_t forward_b_e,
    output core_pkg::reg_idx_t rs1_e,
    output core_pkg::reg_idx_t rs2_e,
    output core_pkg::word_t    pc_target_e,
    output logic               pc_src_e
);

    core_pkg::word_t src_a;
    core_pkg::word_t src_b;
    core_pkg::word_t write_data_e;
    core_pkg::word_t alu_result_e;
    logic            zero;

    always_comb begin
        case (forward_a_e)
            core_pkg::FWD_WB:  src_a = result_w;
            core_pkg::FWD_MEM: src_a = alu_result_m;
            default:           src_a = de.rd1;
        endcase
    end

    // forwarded rs2 doubles as store data
    always_comb begin
        case (forward_b_e)
            core_pkg::FWD_WB:  write_data_e = result_w;
            core_pkg::FWD_MEM: write_data_e = alu_result_m;
            default:           write_data_e = de.rd2;
        endcase
    end

    assign src_b = de.alu_src ? de.imm_ext : write_data_e;

    alu u_alu (
        .a      (src_a),
        .b      (src_b),
        .alu_op (de.alu_op),
        .result (alu_result_e),
        .zero   (zero)
    );

    assign pc_target_e = de.pc + de.imm_ext;
    assign pc_src_e    = (zero & de.branch) | de.jump;
    assign rs1_e       = de.rs1;
    assign rs2_e       = de.rs2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            em.reg_write  <= 1'b0;
            em.result_src <= core_pkg::RES_ALU;
            em.mem_write  <= 1'b0;
        end else begin
            em.reg_write  <= de.reg_write;
            em.result_src <= de.result_src;
            em.mem_write  <= de.mem_write;
        end
    end

    always_ff @(posedge clk) begin
        em.alu_result <= alu_result_e;
        em.write_data <= write_data_e;
        em.rd         <= de.rd;
        em.pc_plus4   <= de.pc_plus4;
    end

endmodule

`default_nettype wire

// File: source/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  core_pkg::reg_idx_t    rs1_d,
    input  core_pkg::reg_idx_t    rs2_d,
    input  core_pkg::reg_idx_t    rs1_e,
    input  core_pkg::reg_idx_t    rs2_e,
    input  core_pkg::reg_idx_t    rd_e,
    input  core_pkg::result_src_t result_src_e,
    exec_mem_io.hz                em,
    input  core_pkg::reg_idx_t    rd_w,
    input  logic                  reg_write_w,
    input  logic                  pc_src_e,
    output core_pkg::fwd_sel_t    forward_a_e,
    output core_pkg::fwd_sel_t    forward_b_e,
    output logic                  stall_f,
    output logic                  stall_d,
    output logic                  flush_d,
    output logic                  flush_e
);

    logic mem_fwd_ok;
    logic lw_stall;

    // alu_result_m only holds the value when memory carries an ALU result
    assign mem_fwd_ok = em.reg_write && (em.result_src == core_pkg::RES_ALU);

    function automatic core_pkg::fwd_sel_t pick(input core_pkg::reg_idx_t rs);
        if (rs == '0)
            return core_pkg::FWD_NONE;
        else if (mem_fwd_ok && rs == em.rd)
            return core_pkg::FWD_MEM;
        else if (reg_write_w && rs == rd_w)
            return core_pkg::FWD_WB;
        else
            return core_pkg::FWD_NONE;
    endfunction

    assign forward_a_e = pick(rs1_e);
    assign forward_b_e = pick(rs2_e);

    // load in execute feeding the instruction in decode
    assign lw_stall = (result_src_e == core_pkg::RES_MEM) && (rd_e != '0) &&
                      (rd_e == rs1_d || rd_e == rs2_d);

    assign stall_f = lw_stall;
    assign stall_d = lw_stall;
    assign flush_d = pc_src_e;
    assign flush_e = lw_stall | pc_src_e;

endmodule

`default_nettype wire

// File: source/riscv_core.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_core (
    input  logic            clk,
    input  logic            rst_n,
    output core_pkg::word_t imem_addr,
    input  core_pkg::word_t imem_rdata,
    output core_pkg::word_t dmem_addr,
    output core_pkg::word_t dmem_wdata,
    output logic            dmem_we,
    input  core_pkg::word_t dmem_rdata
);

    decode_exec_io de_if ();
    exec_mem_io    em_if ();

    core_pkg::word_t       pc_f;
    core_pkg::word_t       pc_plus4_f;
    core_pkg::word_t       instr_d;
    core_pkg::word_t       pc_d;
    core_pkg::word_t       pc_plus4_d;
    core_pkg::reg_idx_t    rs1_d;
    core_pkg::reg_idx_t    rs2_d;
    core_pkg::reg_idx_t    rs1_e;
    core_pkg::reg_idx_t    rs2_e;
    core_pkg::word_t       pc_target_e;
    logic                  pc_src_e;
    core_pkg::fwd_sel_t    forward_a_e;
    core_pkg::fwd_sel_t    forward_b_e;
    logic                  stall_f;
    logic                  stall_d;
    logic                  flush_d;
    logic                  flush_e;
    logic                  reg_write_w;
    core_pkg::result_src_t result_src_w;
    core_pkg::word_t       alu_result_w;
    core_pkg::word_t       read_data_w;
    core_pkg::reg_idx_t    rd_w;
    core_pkg::word_t       pc_plus4_w;
    core_pkg::word_t       result_w;

    // fetch
    assign pc_plus4_f = pc_f + 32'd4;
    assign imem_addr  = pc_f;

    always_ff @(posedge clk) begin
        if (!rst_n)
            pc_f <= '0;
        else if (!stall_f)
            pc_f <= pc_src_e ? pc_target_e : pc_plus4_f;
    end

    // fetch to decode, squashed to a nop on a taken transfer
    always_ff @(posedge clk) begin
        if (!rst_n || flush_d)
            instr_d <= core_pkg::NOP_INSTR;
        else if (!stall_d)
            instr_d <= imem_rdata;
    end

    always_ff @(posedge clk) begin
        if (!stall_d) begin
            pc_d       <= pc_f;
            pc_plus4_d <= pc_plus4_f;
        end
    end

    assign rs1_d = instr_d[19:15];
    assign rs2_d = instr_d[24:20];

    decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_d     (instr_d),
        .pc_d        (pc_d),
        .pc_plus4_d  (pc_plus4_d),
        .flush_e     (flush_e),
        .rd_w        (rd_w),
        .reg_write_w (reg_write_w),
        .result_w    (result_w),
        .de          (de_if)
    );

    exec u_exec (
        .clk          (clk),
        .rst_n        (rst_n),
        .de           (de_if),
        .em           (em_if),
        .alu_result_m (em_if.alu_result),
        .result_w     (result_w),
        .forward_a_e  (forward_a_e),
        .forward_b_e  (forward_b_e),
        .rs1_e        (rs1_e),
        .rs2_e        (rs2_e),
        .pc_target_e  (pc_target_e),
        .pc_src_e     (pc_src_e)
    );

    hazard_unit u_hazard (
        .rs1_d        (rs1_d),
        .rs2_d        (rs2_d),
        .rs1_e        (rs1_e),
        .rs2_e        (rs2_e),
        .rd_e         (de_if.rd),
        .result_src_e (de_if.result_src),
        .em           (em_if),
        .rd_w         (rd_w),
        .reg_write_w  (reg_write_w),
        .pc_src_e     (pc_src_e),
        .forward_a_e  (forward_a_e),
        .forward_b_e  (forward_b_e),
        .stall_f      (stall_f),
        .stall_d      (stall_d),
        .flush_d      (flush_d),
        .flush_e      (flush_e)
    );

    // memory stage
    assign dmem_addr  = em_if.alu_result;
    assign dmem_wdata = em_if.write_data;
    assign dmem_we    = em_if.mem_write;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_write_w  <= 1'b0;
            result_src_w <= core_pkg::RES_ALU;
        end else begin
            reg_write_w  <= em_if.reg_write;
            result_src_w <= em_if.result_src;
        end
    end

    always_ff @(posedge clk) begin
        alu_result_w <= em_if.alu_result;
        read_data_w  <= dmem_rdata;
        rd_w         <= em_if.rd;
        pc_plus4_w   <= em_if.pc_plus4;
    end

    // writeback
    always_comb begin
        case (result_src_w)
            core_pkg::RES_MEM: result_w = read_data_w;
            core_pkg::RES_PC4: result_w = pc_plus4_w;
            default:           result_w = alu_result_w;
        endcase
    end

endmodule

`default_nettype wire

// File: verif/core_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module core_assertions (
    input logic            clk,
    input logic            rst_n,
    input logic            dmem_we,
    input logic            pc_src_e,
    input logic            stall_f,
    input core_pkg::word_t pc_f,
    input core_pkg::word_t instr_d,
    input logic            reg_write_e,
    input logic            mem_write_e
);

    // no store can leave the pipeline right after reset
    assert property (@(posedge clk) $rose(rst_n) |-> !dmem_we)
        else $error("dmem_we high in the first cycle after reset");

    // taken transfer leaves a nop in decode and a bubble in execute
    assert property (@(posedge clk) disable iff (!rst_n)
                     pc_src_e |=> (instr_d == core_pkg::NOP_INSTR) &&
                                  !reg_write_e && !mem_write_e)
        else $error("taken transfer did not squash decode and execute");

    // load-use stall holds fetch and decode, execute gets a bubble
    assert property (@(posedge clk) disable iff (!rst_n)
                     stall_f |=> $stable(pc_f) && $stable(instr_d) &&
                                 !reg_write_e && !mem_write_e)
        else $error("load-use stall did not hold fetch and decode");

endmodule

bind riscv_core core_assertions u_core_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .dmem_we     (dmem_we),
    .pc_src_e    (pc_src_e),
    .stall_f     (stall_f),
    .pc_f        (pc_f),
    .instr_d     (instr_d),
    .reg_write_e (de_if.reg_write),
    .mem_write_e (de_if.mem_write)
);

`default_nettype wire

// File: verif/tb_riscv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_core;

    logic            clk;
    logic            rst_n;
    core_pkg::word_t imem_addr;
    core_pkg::word_t imem_rdata;
    core_pkg::word_t dmem_addr;
    core_pkg::word_t dmem_wdata;
    logic            dmem_we;
    core_pkg::word_t dmem_rdata;

    core_pkg::word_t rom [64];
    core_pkg::word_t dram [64];
    core_pkg::word_t store_addr_q [$];
    core_pkg::word_t store_data_q [$];
    logic [31:0]     lfsr_state;
    int              prog_idx;
    int              error_count;

    riscv_core dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    always #10 clk = ~clk;

    assign imem_rdata = rom[imem_addr[7:2]];
    assign dmem_rdata = dram[dmem_addr[7:2]];

    // data RAM write and store log
    always @(posedge clk) begin
        if (dmem_we) begin
            dram[dmem_addr[7:2]] <= dmem_wdata;
            store_addr_q.push_back(dmem_addr);
            store_data_q.push_back(dmem_wdata);
        end
    end

    function automatic logic [31:0] lfsr_take(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic core_pkg::word_t sx12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic core_pkg::word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, core_pkg::OP_R};
    endfunction

    function automatic core_pkg::word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic core_pkg::word_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], core_pkg::OP_STORE};
    endfunction

    function automatic core_pkg::word_t b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], core_pkg::OP_BRANCH};
    endfunction

    function automatic core_pkg::word_t j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, core_pkg::OP_JAL};
    endfunction

    task automatic put(input core_pkg::word_t instr);
        rom[prog_idx] = instr;
        prog_idx++;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got,
                     expected);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    // hold reset while the ROM and RAM are refilled
    task automatic start_program();
        @(posedge clk);
        #1 rst_n = 1'b0;
        for (int i = 0; i < 64; i++) begin
            rom[i]  = core_pkg::NOP_INSTR;
            dram[i] = 32'hd000_0000 | (i * 4);
        end
        prog_idx = 0;
    endtask

    task automatic release_reset();
        repeat (3) @(posedge clk);
        store_addr_q.delete();
        store_data_q.delete();
        #1 rst_n = 1'b1;
    endtask

    task automatic run_and_check(input string name, input core_pkg::word_t exp_addr [$],
                                 input core_pkg::word_t exp_data [$]);
        int cycles;
        put(j_type(21'd0, 5'd0));
        release_reset();
        cycles = 0;
        while (store_addr_q.size() < exp_addr.size()) begin
            @(posedge clk);
            cycles++;
            if (cycles > 500) begin
                $display("timeout in test %s, only %0d of %0d stores seen", name,
                         store_addr_q.size(), exp_addr.size());
                $display("Finished with errors");
                $fatal(1);
            end
        end
        // anything younger reaches the memory stage within the pipeline depth
        repeat (5) @(posedge clk);
        #1;
        check_value({name, " store count"}, store_addr_q.size(), exp_addr.size());
        for (int i = 0; i < exp_addr.size(); i++) begin
            check_value($sformatf("%s store %0d addr", name, i), store_addr_q[i], exp_addr[i]);
            check_value($sformatf("%s store %0d data", name, i), store_data_q[i], exp_data[i]);
        end
    endtask

    task automatic alu_chain_test();
        logic [11:0]     im [6];
        core_pkg::word_t r [13];
        core_pkg::word_t ea [$];
        core_pkg::word_t ed [$];
        for (int i = 0; i < 6; i++) begin
            im[i] = lfsr_take(12);
        end
        r[0]  = '0;
        r[1]  = sx12(im[0]);
        r[2]  = r[1] + sx12(im[1]);
        r[3]  = r[2] + r[1];
        r[4]  = r[3] - r[1];
        r[5]  = r[4] & r[2];
        r[6]  = r[5] | r[3];
        r[7]  = r[6] ^ r[4];
        r[8]  = ($signed(r[7]) < $signed(r[5])) ? 32'd1 : 32'd0;
        r[9]  = r[7] & sx12(im[2]);
        r[10] = r[9] | sx12(im[3]);
        r[11] = r[10] ^ sx12(im[4]);
        r[12] = ($signed(r[11]) < $signed(sx12(im[5]))) ? 32'd1 : 32'd0;
        start_program();
        put(i_type(im[0], 5'd0, 3'b000, 5'd1, core_pkg::OP_I));
        put(i_type(im[1], 5'd1, 3'b000, 5'd2, core_pkg::OP_I));
        put(r_type(7'h00, 5'd1, 5'd2, 3'b000, 5'd3));
        put(r_type(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
        put(r_type(7'h00, 5'd2, 5'd4, 3'b111, 5'd5));
        put(r_type(7'h00, 5'd3, 5'd5, 3'b110, 5'd6));
        put(r_type(7'h00, 5'd4, 5'd6, 3'b100, 5'd7));
        put(r_type(7'h00, 5'd5, 5'd7, 3'b010, 5'd8));
        put(i_type(im[2], 5'd7, 3'b111, 5'd9, core_pkg::OP_I));
        put(i_type(im[3], 5'd9, 3'b110, 5'd10, core_pkg::OP_I));
        put(i_type(im[4], 5'd10, 3'b100, 5'd11, core_pkg::OP_I));
        put(i_type(im[5], 5'd11, 3'b010, 5'd12, core_pkg::OP_I));
        for (int k = 1; k <= 12; k++) begin
            put(s_type(12'(4 * k), 5'(k), 5'd0));
            ea.push_back(4 * k);
            ed.push_back(r[k]);
        end
        run_and_check("alu_chain", ea, ed);
    endtask

    task automatic load_use_test();
        logic [11:0]     im;
        core_pkg::word_t v;
        im = lfsr_take(12);
        v  = sx12(im);
        start_program();
        put(i_type(im, 5'd0, 3'b000, 5'd1, core_pkg::OP_I));
        put(s_type(12'd8, 5'd1, 5'd0));
        put(i_type(12'd8, 5'd0, 3'b010, 5'd2, core_pkg::OP_LOAD));
        put(r_type(7'h00, 5'd1, 5'd2, 3'b000, 5'd3));
        put(s_type(12'd12, 5'd3, 5'd0));
        run_and_check("load_use", '{32'd8, 32'd12}, '{v, v + v});
    endtask

    task automatic branch_test();
        start_program();
        put(i_type(12'd5, 5'd0, 3'b000, 5'd1, core_pkg::OP_I));
        put(i_type(12'd5, 5'd0, 3'b000, 5'd2, core_pkg::OP_I));
        put(i_type(12'd7, 5'd0, 3'b000, 5'd3, core_pkg::OP_I));
        // taken, skips the next two stores
        put(b_type(13'd12, 5'd2, 5'd1));
        put(s_type(12'd0, 5'd1, 5'd0));
        put(s_type(12'd4, 5'd1, 5'd0));
        put(b_type(13'd8, 5'd3, 5'd1));
        put(s_type(12'd8, 5'd3, 5'd0));
        put(s_type(12'd12, 5'd2, 5'd0));
        run_and_check("branch", '{32'd8, 32'd12}, '{32'd7, 32'd5});
    endtask

    task automatic jal_test();
        start_program();
        put(j_type(21'd12, 5'd5));
        put(s_type(12'd0, 5'd0, 5'd0));
        put(s_type(12'd4, 5'd0, 5'd0));
        put(s_type(12'd16, 5'd5, 5'd0));
        put(i_type(12'd1, 5'd5, 3'b000, 5'd6, core_pkg::OP_I));
        put(s_type(12'd20, 5'd6, 5'd0));
        run_and_check("jal", '{32'd16, 32'd20}, '{32'd4, 32'd5});
    endtask

    task automatic x0_test();
        start_program();
        put(i_type(12'd77, 5'd0, 3'b000, 5'd1, core_pkg::OP_I));
        put(i_type(12'd5, 5'd1, 3'b000, 5'd0, core_pkg::OP_I));
        put(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd2));
        put(s_type(12'd24, 5'd0, 5'd0));
        put(s_type(12'd28, 5'd2, 5'd0));
        run_and_check("x0", '{32'd24, 32'd28}, '{32'd0, 32'd77});
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        lfsr_state  = 32'h2082_acb3;
        prog_idx    = 0;
        error_count = 0;
        alu_chain_test();
        load_use_test();
        branch_test();
        jal_test();
        x0_test();
        if (error_count == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
source/core_pkg.sv
source/stage_if.sv
source/alu.sv
source/regfile.sv
source/decode.sv
source/exec.sv
source/hazard_unit.sv
source/riscv_core.sv
verif/core_assertions.sv
verif/tb_riscv_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_riscv_core -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
    exit 1
fi
grep -q "Finished with no errors" sim.log
